/* design/ack_nak_dllp_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pcie_rx_defines.svh"

module ack_nak_dllp_gen (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   verdict_valid_i,
  input  pcie_dll_pkg::dllp_kind_e    verdict_kind_i,
  input  pcie_dll_pkg::seq_num_t      verdict_seq_i,
  output logic                        busy_o,
  output logic [`PCIE_DW_WIDTH-1:0]   dllp_data_o,
  output logic                        dllp_valid_o,
  output logic                        dllp_last_o,
  input  wire logic                   dllp_ready_i
);

  import pcie_dll_pkg::*;

  localparam int PadW = `PCIE_DW_WIDTH - 8 - `PCIE_SEQ_WIDTH;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CRC,
    ST_BEAT1,
    ST_BEAT2
  } state_e;

  state_e                    state_q;
  dllp_kind_e                kind_q;
  seq_num_t                  seq_q;
  logic [15:0]               crc_q;
  logic [`PCIE_DW_WIDTH-1:0] beat1;

  // type byte on top, sequence in the low bits
  assign beat1 = {dllp_type_byte(kind_q), {PadW{1'b0}}, seq_q};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (verdict_valid_i) begin
            state_q <= ST_CRC;
          end
        end
        ST_CRC: begin
          state_q <= ST_BEAT1;
        end
        ST_BEAT1: begin
          if (dllp_ready_i) begin
            state_q <= ST_BEAT2;
          end
        end
        default: begin
          if (dllp_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && verdict_valid_i) begin
      kind_q <= verdict_kind_i;
      seq_q  <= verdict_seq_i;
    end
    // crc kept already inverted, ready for the wire
    if (state_q == ST_CRC) begin
      crc_q <= ~crc16_step(DLLP_CRC_INIT, beat1);
    end
  end

  assign busy_o       = (state_q != ST_IDLE);
  assign dllp_valid_o = (state_q == ST_BEAT1) || (state_q == ST_BEAT2);
  assign dllp_last_o  = (state_q == ST_BEAT2);
  assign dllp_data_o  = (state_q == ST_BEAT2) ? {{(`PCIE_DW_WIDTH-16){1'b0}}, crc_q} : beat1;

endmodule

`default_nettype wire

/* design/dll_rx_framer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pcie_rx_defines.svh"

module dll_rx_framer (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic                      link_up_i,
  input  rx_buffer_pkg::buf_word_t       rx_data_i,
  input  wire logic                      rx_valid_i,
  input  wire logic                      rx_last_i,
  output logic                           rx_ready_o,
  output logic                           wr_en_o,
  output rx_buffer_pkg::slot_addr_t      wr_addr_o,
  output rx_buffer_pkg::buf_word_t       wr_data_o,
  output logic                           commit_o,
  output rx_buffer_pkg::dw_len_t         commit_len_o,
  input  wire logic                      buf_full_i,
  output logic                           verdict_valid_o,
  output pcie_dll_pkg::dllp_kind_e       verdict_kind_o,
  output pcie_dll_pkg::seq_num_t         verdict_seq_o,
  input  wire logic                      dllp_busy_i
);

  import pcie_dll_pkg::*;
  import rx_buffer_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEQ,
    ST_BODY,
    ST_VERDICT
  } state_e;

  state_e      state_q;
  logic        rx_fire;
  logic        slot_room;
  logic        tlp_good;
  logic [31:0] crc_q;
  logic [31:0] crc_cmp;
  logic        lcrc_ok_q;
  logic        too_long_q;
  buf_word_t   hold_q;
  dw_len_t     count_q;
  slot_idx_t   tail_q;
  seq_num_t    expected_q;
  seq_num_t    rx_seq_q;

  assign rx_fire   = rx_valid_i && rx_ready_o;
  assign slot_room = (count_q < dw_len_t'(`RX_SLOT_DEPTH_DW));

  // in body the held word belongs to the crc before the new word is judged
  assign crc_cmp = (state_q == ST_BODY) ? crc32_step(crc_q, hold_q) : crc_q;

  // empty tlp counts as malformed
  assign tlp_good = lcrc_ok_q && !too_long_q && (count_q != '0);

  always_comb begin
    case (state_q)
      ST_IDLE:         rx_ready_o = link_up_i && !buf_full_i;
      ST_SEQ, ST_BODY: rx_ready_o = 1'b1;
      default:         rx_ready_o = 1'b0;
    endcase
  end

  // held word is written once the next word proves it was not the lcrc
  assign wr_en_o   = (state_q == ST_BODY) && rx_fire && slot_room;
  assign wr_addr_o = slot_word_addr(tail_q, count_q);
  assign wr_data_o = hold_q;

  assign verdict_valid_o = (state_q == ST_VERDICT) && !dllp_busy_i;
  assign commit_o        = verdict_valid_o && tlp_good && (rx_seq_q == expected_q);
  assign commit_len_o    = count_q;
  assign verdict_kind_o  = tlp_good ? DLLP_ACK : DLLP_NAK;

  // duplicate or rejected packets report the last good sequence
  assign verdict_seq_o = commit_o ? rx_seq_q : seq_num_t'(expected_q - 1'b1);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      count_q    <= '0;
      too_long_q <= 1'b0;
      tail_q     <= '0;
      expected_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (rx_fire) begin
            count_q    <= '0;
            too_long_q <= 1'b0;
            state_q    <= ST_SEQ;
          end
        end
        ST_SEQ: begin
          if (rx_fire) begin
            state_q <= rx_last_i ? ST_VERDICT : ST_BODY;
          end
        end
        ST_BODY: begin
          if (rx_fire) begin
            if (slot_room) begin
              count_q <= count_q + 1'b1;
            end else begin
              too_long_q <= 1'b1;
            end
            if (rx_last_i) begin
              state_q <= ST_VERDICT;
            end
          end
        end
        default: begin
          // wait here while the previous dllp is still going out
          if (!dllp_busy_i) begin
            if (commit_o) begin
              tail_q     <= tail_q + 1'b1;
              expected_q <= expected_q + 1'b1;
            end
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && rx_fire) begin
      crc_q    <= crc32_step(LCRC_INIT, rx_data_i);
      rx_seq_q <= rx_data_i[`PCIE_SEQ_WIDTH-1:0];
    end
    if ((state_q == ST_SEQ || state_q == ST_BODY) && rx_fire) begin
      hold_q    <= rx_data_i;
      crc_q     <= crc_cmp;
      // only meaningful on the beat flagged last
      lcrc_ok_q <= (~crc_cmp == rx_data_i);
    end
  end

endmodule

`default_nettype wire

/* design/dll_rx_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pcie_rx_defines.svh"

module dll_rx_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   link_up_i,
  input  rx_buffer_pkg::buf_word_t    rx_data_i,
  input  wire logic                   rx_valid_i,
  input  wire logic                   rx_last_i,
  output logic                        rx_ready_o,
  output rx_buffer_pkg::buf_word_t    tlp_data_o,
  output logic                        tlp_valid_o,
  output logic                        tlp_last_o,
  input  wire logic                   tlp_ready_i,
  output logic [`PCIE_DW_WIDTH-1:0]   dllp_data_o,
  output logic                        dllp_valid_o,
  output logic                        dllp_last_o,
  input  wire logic                   dllp_ready_i
);

  import pcie_dll_pkg::*;
  import rx_buffer_pkg::*;

  // framer to buffer
  logic       buf_wr_en;
  slot_addr_t buf_wr_addr;
  buf_word_t  buf_wr_data;
  logic       buf_commit;
  dw_len_t    buf_commit_len;
  logic       buf_full;

  // buffer to stream side
  logic       buf_empty;
  dw_len_t    buf_head_len;
  slot_idx_t  buf_head_slot;
  slot_addr_t buf_rd_addr;
  buf_word_t  buf_rd_data;
  logic       buf_pop;

  // framer to dllp generator
  logic       verdict_valid;
  dllp_kind_e verdict_kind;
  seq_num_t   verdict_seq;
  logic       dllp_busy;

  dll_rx_framer u_framer (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .link_up_i       (link_up_i),
    .rx_data_i       (rx_data_i),
    .rx_valid_i      (rx_valid_i),
    .rx_last_i       (rx_last_i),
    .rx_ready_o      (rx_ready_o),
    .wr_en_o         (buf_wr_en),
    .wr_addr_o       (buf_wr_addr),
    .wr_data_o       (buf_wr_data),
    .commit_o        (buf_commit),
    .commit_len_o    (buf_commit_len),
    .buf_full_i      (buf_full),
    .verdict_valid_o (verdict_valid),
    .verdict_kind_o  (verdict_kind),
    .verdict_seq_o   (verdict_seq),
    .dllp_busy_i     (dllp_busy)
  );

  rx_slot_buffer #(
    .word_t (buf_word_t)
  ) u_buffer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wr_en_i      (buf_wr_en),
    .wr_addr_i    (buf_wr_addr),
    .wr_data_i    (buf_wr_data),
    .commit_i     (buf_commit),
    .commit_len_i (buf_commit_len),
    .rd_addr_i    (buf_rd_addr),
    .rd_data_o    (buf_rd_data),
    .pop_i        (buf_pop),
    .full_o       (buf_full),
    .empty_o      (buf_empty),
    .head_len_o   (buf_head_len),
    .head_slot_o  (buf_head_slot)
  );

  tlp_stream_out u_stream (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .empty_i     (buf_empty),
    .head_len_i  (buf_head_len),
    .head_slot_i (buf_head_slot),
    .rd_addr_o   (buf_rd_addr),
    .rd_data_i   (buf_rd_data),
    .pop_o       (buf_pop),
    .tlp_data_o  (tlp_data_o),
    .tlp_valid_o (tlp_valid_o),
    .tlp_last_o  (tlp_last_o),
    .tlp_ready_i (tlp_ready_i)
  );

  ack_nak_dllp_gen u_dllp_gen (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .verdict_valid_i (verdict_valid),
    .verdict_kind_i  (verdict_kind),
    .verdict_seq_i   (verdict_seq),
    .busy_o          (dllp_busy),
    .dllp_data_o     (dllp_data_o),
    .dllp_valid_o    (dllp_valid_o),
    .dllp_last_o     (dllp_last_o),
    .dllp_ready_i    (dllp_ready_i)
  );

endmodule

`default_nettype wire

/* design/pcie_dll_pkg.sv */
`default_nettype none

`include "pcie_rx_defines.svh"

package pcie_dll_pkg;

  // ack/nak selector carried with each verdict
  typedef enum logic {
    DLLP_ACK = 1'b0,
    DLLP_NAK = 1'b1
  } dllp_kind_e;

  typedef logic [`PCIE_SEQ_WIDTH-1:0] seq_num_t;

  localparam logic [7:0] DLLP_TYPE_ACK = 8'h00;
  localparam logic [7:0] DLLP_TYPE_NAK = 8'h10;

  localparam logic [31:0] LCRC_INIT = 32'hFFFF_FFFF;
  localparam logic [15:0] DLLP_CRC_INIT = 16'hFFFF;

  // 04C11DB7 bit-reversed for the lsb-first shifter
  localparam logic [31:0] LCRC_POLY_REFL = 32'hEDB8_8320;
  localparam logic [15:0] DLLP_CRC_POLY = 16'h100B;

  function automatic logic [7:0] dllp_type_byte(input dllp_kind_e kind);
    return (kind == DLLP_NAK) ? DLLP_TYPE_NAK : DLLP_TYPE_ACK;
  endfunction

  // one dword into the lcrc, byte 0 first, each byte lsb first
  function automatic logic [31:0] crc32_step(input logic [31:0] crc,
                                             input logic [`PCIE_DW_WIDTH-1:0] data);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < `PCIE_DW_WIDTH; i++) begin
      fb = c[0] ^ data[i];
      c  = c >> 1;
      if (fb) begin
        c = c ^ LCRC_POLY_REFL;
      end
    end
    return c;
  endfunction

  // one dword into the dllp crc, byte 0 first, msb first inside a byte
  function automatic logic [15:0] crc16_step(input logic [15:0] crc,
                                             input logic [`PCIE_DW_WIDTH-1:0] data);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int b = 0; b < `PCIE_DW_WIDTH / 8; b++) begin
      for (int i = 7; i >= 0; i--) begin
        fb = c[15] ^ data[8*b+i];
        c  = {c[14:0], 1'b0};
        if (fb) begin
          c = c ^ DLLP_CRC_POLY;
        end
      end
    end
    return c;
  endfunction

endpackage

`default_nettype wire

/* design/pcie_rx_defines.svh */
`ifndef PCIE_RX_DEFINES_SVH
`define PCIE_RX_DEFINES_SVH

// link word width in bits
`define PCIE_DW_WIDTH 32

// sequence number width
`define PCIE_SEQ_WIDTH 12

// receive buffer geometry
`define RX_SLOT_COUNT 4

// max tlp dwords per slot, longer packets are rejected
`define RX_SLOT_DEPTH_DW 16

`endif

/* design/rx_buffer_pkg.sv */
`default_nettype none

`include "pcie_rx_defines.svh"

package rx_buffer_pkg;

  localparam int SLOT_IDX_W = $clog2(`RX_SLOT_COUNT);
  localparam int SLOT_OFF_W = $clog2(`RX_SLOT_DEPTH_DW);

  // slot number plus wrap bit
  typedef logic [SLOT_IDX_W:0] slot_idx_t;

  typedef logic [SLOT_IDX_W+SLOT_OFF_W-1:0] slot_addr_t;

  // wide enough to hold a full slot count
  typedef logic [SLOT_OFF_W:0] dw_len_t;

  typedef logic [`PCIE_DW_WIDTH-1:0] buf_word_t;

  // ram address of a dword inside a slot
  function automatic slot_addr_t slot_word_addr(input slot_idx_t slot, input dw_len_t offset);
    return {slot[SLOT_IDX_W-1:0], offset[SLOT_OFF_W-1:0]};
  endfunction

endpackage

`default_nettype wire

/* design/rx_slot_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pcie_rx_defines.svh"

module rx_slot_buffer #(
  parameter type word_t = rx_buffer_pkg::buf_word_t
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   wr_en_i,
  input  rx_buffer_pkg::slot_addr_t   wr_addr_i,
  input  word_t                       wr_data_i,
  input  wire logic                   commit_i,
  input  rx_buffer_pkg::dw_len_t      commit_len_i,
  input  rx_buffer_pkg::slot_addr_t   rd_addr_i,
  output word_t                       rd_data_o,
  input  wire logic                   pop_i,
  output logic                        full_o,
  output logic                        empty_o,
  output rx_buffer_pkg::dw_len_t      head_len_o,
  output rx_buffer_pkg::slot_idx_t    head_slot_o
);

  import rx_buffer_pkg::*;

  localparam int WordCount = `RX_SLOT_COUNT * `RX_SLOT_DEPTH_DW;

  word_t     mem     [WordCount];
  dw_len_t   len_tab [`RX_SLOT_COUNT];
  slot_idx_t head_q;
  slot_idx_t tail_q;

  // write port from the framer, registered read port for the stream side
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
    rd_data_o <= mem[rd_addr_i];
  end

  // length lands together with the tail move
  always_ff @(posedge clk_i) begin
    if (commit_i) begin
      len_tab[tail_q[SLOT_IDX_W-1:0]] <= commit_len_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (commit_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop_i) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  // same slot, wrap bits differ -> every slot taken
  assign full_o = (head_q[SLOT_IDX_W] != tail_q[SLOT_IDX_W]) &&
                  (head_q[SLOT_IDX_W-1:0] == tail_q[SLOT_IDX_W-1:0]);
  assign empty_o = (head_q == tail_q);

  assign head_len_o  = len_tab[head_q[SLOT_IDX_W-1:0]];
  assign head_slot_o = head_q;

endmodule

`default_nettype wire

/* design/tlp_stream_out.sv */
`timescale 1ns/100ps
`default_nettype none

module tlp_stream_out (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   empty_i,
  input  rx_buffer_pkg::dw_len_t      head_len_i,
  input  rx_buffer_pkg::slot_idx_t    head_slot_i,
  output rx_buffer_pkg::slot_addr_t   rd_addr_o,
  input  rx_buffer_pkg::buf_word_t    rd_data_i,
  output logic                        pop_o,
  output rx_buffer_pkg::buf_word_t    tlp_data_o,
  output logic                        tlp_valid_o,
  output logic                        tlp_last_o,
  input  wire logic                   tlp_ready_i
);

  import rx_buffer_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PREFETCH,
    ST_STREAM,
    ST_DONE
  } state_e;

  state_e    state_q;
  dw_len_t   rd_idx_q;
  dw_len_t   rd_idx_d;
  dw_len_t   word_num;
  logic      out_fire;
  logic      load;
  buf_word_t tlp_data_q;
  logic      tlp_valid_q;
  logic      tlp_last_q;

  assign out_fire = tlp_valid_q && tlp_ready_i;

  // 1-based number of the word being loaded
  assign word_num = rd_idx_q + 1'b1;

  // output register takes a new word on prefetch or on a non-final handshake
  assign load = (state_q == ST_PREFETCH) ||
                (state_q == ST_STREAM && out_fire && !tlp_last_q);

  always_comb begin
    if (state_q == ST_DONE) begin
      rd_idx_d = '0;
    end else if (load) begin
      rd_idx_d = word_num;
    end else begin
      rd_idx_d = rd_idx_q;
    end
  end

  // address runs from the next index so rd_data_i always holds word rd_idx_q
  assign rd_addr_o = slot_word_addr(head_slot_i, rd_idx_d);
  assign pop_o     = (state_q == ST_DONE);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      rd_idx_q    <= '0;
      tlp_valid_q <= 1'b0;
      tlp_last_q  <= 1'b0;
    end else begin
      rd_idx_q <= rd_idx_d;
      case (state_q)
        ST_IDLE: begin
          if (!empty_i) begin
            state_q <= ST_PREFETCH;
          end
        end
        ST_PREFETCH: begin
          tlp_valid_q <= 1'b1;
          tlp_last_q  <= (word_num == head_len_i);
          state_q     <= ST_STREAM;
        end
        ST_STREAM: begin
          if (out_fire) begin
            if (tlp_last_q) begin
              tlp_valid_q <= 1'b0;
              tlp_last_q  <= 1'b0;
              state_q     <= ST_DONE;
            end else begin
              tlp_last_q <= (word_num == head_len_i);
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      tlp_data_q <= rd_data_i;
    end
  end

  assign tlp_data_o  = tlp_data_q;
  assign tlp_valid_o = tlp_valid_q;
  assign tlp_last_o  = tlp_last_q;

endmodule

`default_nettype wire

/* dv/dll_rx_tb_cases.svh */
`ifndef DLL_RX_TB_CASES_SVH
`define DLL_RX_TB_CASES_SVH

task automatic load_cases();
  // name, seq, tlp dwords, corrupt lcrc, tlp_ready pattern, link up, expect nak, expect forward
  add_case("nak_at_reset",  0,  3, 1'b1, 8'hff,       1'b1, 1'b1, 1'b0);
  add_case("good_seq0",     0,  4, 1'b0, 8'hff,       1'b1, 1'b0, 1'b1);
  add_case("good_seq1",     1,  1, 1'b0, 8'b10110110, 1'b1, 1'b0, 1'b1);
  add_case("good_seq2",     2, 16, 1'b0, 8'h55,       1'b1, 1'b0, 1'b1);
  add_case("bad_lcrc",      3,  5, 1'b1, 8'hff,       1'b1, 1'b1, 1'b0);
  add_case("good_seq3",     3,  7, 1'b0, 8'hff,       1'b1, 1'b0, 1'b1);
  add_case("dup_seq2",      2,  3, 1'b0, 8'hff,       1'b1, 1'b0, 1'b0);
  add_case("too_long",      4, 17, 1'b0, 8'hff,       1'b1, 1'b1, 1'b0);
  add_case("good_seq4",     4,  2, 1'b0, 8'hff,       1'b1, 1'b0, 1'b1);
  add_case("link_down",     5,  3, 1'b0, 8'hff,       1'b0, 1'b0, 1'b0);
  // tlp_ready held low, the fifth packet finds every slot taken
  add_case("hold_seq5",     5,  3, 1'b0, 8'h00,       1'b1, 1'b0, 1'b1);
  add_case("hold_seq6",     6,  6, 1'b0, 8'h00,       1'b1, 1'b0, 1'b1);
  add_case("hold_seq7",     7,  2, 1'b0, 8'h00,       1'b1, 1'b0, 1'b1);
  add_case("hold_seq8",     8,  8, 1'b0, 8'h00,       1'b1, 1'b0, 1'b1);
  add_case("hold_seq9",     9,  4, 1'b0, 8'h00,       1'b1, 1'b0, 1'b1);
  add_case("after_release", 10, 9, 1'b0, 8'hcc,       1'b1, 1'b0, 1'b1);
  add_case("future_seq",    20, 2, 1'b0, 8'hff,       1'b1, 1'b0, 1'b0);
  add_case("good_seq11",    11, 16, 1'b0, 8'h3f,      1'b1, 1'b0, 1'b1);
endtask

`endif

/* dv/dll_rx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pcie_rx_defines.svh"

module dll_rx_tb;

  import pcie_dll_pkg::*;
  import rx_buffer_pkg::*;

  localparam int ClkPeriod  = 40;
  localparam int DriveDelay = 5;

  logic                      clk_i;
  logic                      rst_i;
  logic                      link_up_i;
  buf_word_t                 rx_data_i;
  logic                      rx_valid_i;
  logic                      rx_last_i;
  logic                      rx_ready_o;
  buf_word_t                 tlp_data_o;
  logic                      tlp_valid_o;
  logic                      tlp_last_o;
  logic                      tlp_ready_i;
  logic [`PCIE_DW_WIDTH-1:0] dllp_data_o;
  logic                      dllp_valid_o;
  logic                      dllp_last_o;
  logic                      dllp_ready_i;

  // case table
  string      case_name[$];
  int         case_seq[$];
  int         case_len[$];
  bit         case_corrupt[$];
  logic [7:0] case_pattern[$];
  bit         case_link[$];
  bit         case_nak[$];
  bit         case_fwd[$];

  // expected traffic
  buf_word_t   exp_tlp_word[$];
  bit          exp_tlp_last[$];
  string       exp_tlp_name[$];
  logic [31:0] exp_dllp_word[$];
  bit          exp_dllp_last[$];
  string       exp_dllp_name[$];

  seq_num_t    expected_seq;
  int          pending_tlps;
  logic [31:0] rng_state;
  logic [7:0]  cur_pattern;
  bit          release_hold;
  logic [7:0]  pattern_q;
  bit          release_q;
  int          ready_tick;
  int          full_checks;
  int          cycle_count;
  int          cycle_limit;
  bit          tlp_stall_q;
  buf_word_t   tlp_hold_data;
  bit          tlp_hold_last;
  bit          dllp_stall_q;
  logic [31:0] dllp_hold_data;

  dll_rx_top dll_rx_top_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .link_up_i    (link_up_i),
    .rx_data_i    (rx_data_i),
    .rx_valid_i   (rx_valid_i),
    .rx_last_i    (rx_last_i),
    .rx_ready_o   (rx_ready_o),
    .tlp_data_o   (tlp_data_o),
    .tlp_valid_o  (tlp_valid_o),
    .tlp_last_o   (tlp_last_o),
    .tlp_ready_i  (tlp_ready_i),
    .dllp_data_o  (dllp_data_o),
    .dllp_valid_o (dllp_valid_o),
    .dllp_last_o  (dllp_last_o),
    .dllp_ready_i (dllp_ready_i)
  );

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic value_error(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s: %s expected %h, actual %h", test, what, exp, act);
    abort_run();
  endtask

  task automatic general_error(input string msg);
    $display("ERROR: %s", msg);
    abort_run();
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_case(input string name, input int seq, input int len, input bit corrupt,
                          input logic [7:0] pattern, input bit link, input bit nak,
                          input bit fwd);
    case_name.push_back(name);
    case_seq.push_back(seq);
    case_len.push_back(len);
    case_corrupt.push_back(corrupt);
    case_pattern.push_back(pattern);
    case_link.push_back(link);
    case_nak.push_back(nak);
    case_fwd.push_back(fwd);
  endtask

  `include "dll_rx_tb_cases.svh"

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // pattern is latched at the edge and applied a little later
  initial begin
    ready_tick   = 0;
    tlp_ready_i  = 1'b0;
    dllp_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      pattern_q = cur_pattern;
      release_q = release_hold;
      #DriveDelay;
      ready_tick++;
      tlp_ready_i  = release_q || pattern_q[ready_tick % 8];
      dllp_ready_i = (ready_tick % 3) != 0;
    end
  end

  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    forever begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        general_error($sformatf("timeout, run exceeded %0d cycles", cycle_limit));
      end
    end
  end

  task automatic check_tlp_beat();
    if (tlp_stall_q) begin
      assert (tlp_valid_o && tlp_data_o == tlp_hold_data && tlp_last_o == tlp_hold_last)
        else general_error("TLP beat changed while tlp_ready_i was low");
    end
    if (tlp_valid_o && tlp_ready_i) begin
      if (exp_tlp_word.size() == 0) begin
        general_error("TLP beat arrived with no TLP expected");
      end else begin
        assert (tlp_data_o == exp_tlp_word[0])
          else value_error(exp_tlp_name[0], "tlp_data_o", exp_tlp_word[0], tlp_data_o);
        assert (tlp_last_o == exp_tlp_last[0])
          else value_error(exp_tlp_name[0], "tlp_last_o", exp_tlp_last[0], tlp_last_o);
        if (exp_tlp_last[0]) begin
          pending_tlps--;
        end
        void'(exp_tlp_word.pop_front());
        void'(exp_tlp_last.pop_front());
        void'(exp_tlp_name.pop_front());
      end
    end
    tlp_stall_q   = tlp_valid_o && !tlp_ready_i;
    tlp_hold_data = tlp_data_o;
    tlp_hold_last = tlp_last_o;
  endtask

  task automatic check_dllp_beat();
    if (dllp_stall_q) begin
      assert (dllp_valid_o && dllp_data_o == dllp_hold_data)
        else general_error("DLLP beat changed while dllp_ready_i was low");
    end
    if (dllp_valid_o && dllp_ready_i) begin
      if (exp_dllp_word.size() == 0) begin
        general_error("DLLP beat sent with no DLLP expected");
      end else begin
        assert (dllp_data_o == exp_dllp_word[0])
          else value_error(exp_dllp_name[0], "dllp_data_o", exp_dllp_word[0], dllp_data_o);
        assert (dllp_last_o == exp_dllp_last[0])
          else value_error(exp_dllp_name[0], "dllp_last_o", exp_dllp_last[0], dllp_last_o);
        void'(exp_dllp_word.pop_front());
        void'(exp_dllp_last.pop_front());
        void'(exp_dllp_name.pop_front());
      end
    end
    dllp_stall_q   = dllp_valid_o && !dllp_ready_i;
    dllp_hold_data = dllp_data_o;
  endtask

  // monitors sample mid-cycle away from both drive points
  always @(negedge clk_i) begin
    if (!rst_i) begin
      check_tlp_beat();
      check_dllp_beat();
    end
  end

  task automatic send_word(input buf_word_t data, input bit last);
    rx_data_i  = data;
    rx_valid_i = 1'b1;
    rx_last_i  = last;
    @(negedge clk_i);
    while (!rx_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic wait_for_dllps();
    while (exp_dllp_word.size() != 0) begin
      @(posedge clk_i);
      #DriveDelay;
    end
  endtask

  // all slots hold unread TLPs so the framer must refuse the next packet
  task automatic check_full_stall(input int row, input buf_word_t seq_word);
    rx_data_i  = seq_word;
    rx_valid_i = 1'b1;
    rx_last_i  = 1'b0;
    repeat (10) begin
      @(negedge clk_i);
      assert (!rx_ready_o)
        else value_error(case_name[row], "rx_ready_o with full buffer", 0, rx_ready_o);
    end
    release_hold = 1'b1;
    full_checks++;
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic run_link_down(input int row);
    link_up_i  = 1'b0;
    rx_data_i  = buf_word_t'(seq_num_t'(case_seq[row]));
    rx_valid_i = 1'b1;
    rx_last_i  = 1'b0;
    repeat (8) begin
      @(negedge clk_i);
      assert (!rx_ready_o)
        else value_error(case_name[row], "rx_ready_o with link down", 0, rx_ready_o);
    end
    @(posedge clk_i);
    #DriveDelay;
    rx_valid_i = 1'b0;
    repeat (4) begin
      @(posedge clk_i);
    end
    #DriveDelay;
    link_up_i = 1'b1;
  endtask

  task automatic run_packet(input int row);
    buf_word_t   payload[$];
    buf_word_t   seq_word;
    buf_word_t   lcrc;
    logic [31:0] crc;
    logic [31:0] beat1;
    bit          good;
    bit          fwd;
    bit          nak;
    seq_num_t    dllp_seq;
    link_up_i    = 1'b1;
    cur_pattern  = case_pattern[row];
    release_hold = 1'b0;
    seq_word     = buf_word_t'(seq_num_t'(case_seq[row]));
    crc          = crc32_step(LCRC_INIT, seq_word);
    for (int i = 0; i < case_len[row]; i++) begin
      rng_state = xorshift32(rng_state);
      payload.push_back(rng_state);
      crc = crc32_step(crc, rng_state);
    end
    lcrc = ~crc;
    if (case_corrupt[row]) begin
      lcrc = lcrc ^ 32'h0000_0100;
    end
    if (case_pattern[row] == 8'h00 && pending_tlps >= `RX_SLOT_COUNT) begin
      check_full_stall(row, seq_word);
    end
    // receiver rules
    good = !case_corrupt[row] && case_len[row] > 0 && case_len[row] <= `RX_SLOT_DEPTH_DW;
    fwd  = good && (seq_num_t'(case_seq[row]) == expected_seq);
    nak  = !good;
    assert (fwd == case_fwd[row] && nak == case_nak[row])
      else general_error({"table row ", case_name[row], " disagrees with the receive rules"});
    dllp_seq = fwd ? expected_seq : seq_num_t'(expected_seq - 1'b1);
    if (fwd) begin
      foreach (payload[i]) begin
        exp_tlp_word.push_back(payload[i]);
        exp_tlp_last.push_back(i == payload.size() - 1);
        exp_tlp_name.push_back(case_name[row]);
      end
      pending_tlps++;
      expected_seq++;
    end
    beat1 = {(nak ? 8'h10 : 8'h00), 12'h000, dllp_seq};
    exp_dllp_word.push_back(beat1);
    exp_dllp_last.push_back(1'b0);
    exp_dllp_name.push_back(case_name[row]);
    exp_dllp_word.push_back({16'h0000, ~crc16_step(DLLP_CRC_INIT, beat1)});
    exp_dllp_last.push_back(1'b1);
    exp_dllp_name.push_back(case_name[row]);
    send_word(seq_word, 1'b0);
    foreach (payload[i]) begin
      send_word(payload[i], 1'b0);
    end
    send_word(lcrc, 1'b1);
    rx_valid_i = 1'b0;
    rx_last_i  = 1'b0;
    wait_for_dllps();
  endtask

  initial begin
    rst_i        = 1'b1;
    link_up_i    = 1'b0;
    rx_data_i    = '0;
    rx_valid_i   = 1'b0;
    rx_last_i    = 1'b0;
    cur_pattern  = 8'hff;
    release_hold = 1'b0;
    rng_state    = 32'h14b67c1b;
    expected_seq = '0;
    pending_tlps = 0;
    full_checks  = 0;
    tlp_stall_q  = 1'b0;
    dllp_stall_q = 1'b0;
    load_cases();
    cycle_limit = 200 * case_name.size() + 100;
    repeat (2) begin
      @(posedge clk_i);
    end
    #DriveDelay;
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (!rx_ready_o) else value_error("reset", "rx_ready_o", 0, rx_ready_o);
    assert (!tlp_valid_o) else value_error("reset", "tlp_valid_o", 0, tlp_valid_o);
    assert (!dllp_valid_o) else value_error("reset", "dllp_valid_o", 0, dllp_valid_o);
    @(posedge clk_i);
    #DriveDelay;
    foreach (case_name[row]) begin
      if (case_link[row]) begin
        run_packet(row);
      end else begin
        run_link_down(row);
      end
    end
    // let the buffered TLPs drain
    cur_pattern  = 8'hff;
    release_hold = 1'b1;
    while (pending_tlps != 0 || exp_tlp_word.size() != 0) begin
      @(posedge clk_i);
      #DriveDelay;
    end
    assert (full_checks == 1) else general_error("buffer never filled under TLP back-pressure");
    repeat (4) begin
      @(posedge clk_i);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
+incdir+dv
design/pcie_dll_pkg.sv
design/rx_buffer_pkg.sv
design/dll_rx_framer.sv
design/rx_slot_buffer.sv
design/tlp_stream_out.sv
design/ack_nak_dllp_gen.sv
design/dll_rx_top.sv
dv/dll_rx_tb.sv
